// File: verif/program.hex
// One 16-bit instruction word per line, address 0 first
// Fields: op[15:12] rd[11:9] rs[8:6] rt[5:3] imm6[5:0] imm8[7:0]
7205    // 00 li   r1, 5
740C    // 01 li   r2, 12
1650    // 02 add  r3, r1, r2
28C8    // 03 sub  r4, r3, r1
3B10    // 04 and  r5, r4, r2
4D48    // 05 or   r6, r5, r1
5E70    // 06 slt  r7, r1, r6
627D    // 07 addi r1, r1, -3
9644    // 08 sw   r3, 4(r1)
8444    // 09 lw   r2, 4(r1)
1890    // 0a add  r4, r2, r2
A102    // 0b beqz r4, +2 not taken
7A00    // 0c li   r5, 0
A142    // 0d beqz r5, +2 taken
7C77    // 0e li   r6, 0x77 skipped
7E66    // 0f li   r7, 0x66 skipped
B003    // 10 b    +3
7C55    // 11 li   r6, 0x55 skipped
7E44    // 12 li   r7, 0x44 skipped
F000    // 13 halt skipped
6E3F    // 14 addi r7, r0, -1
5DC8    // 15 slt  r6, r7, r1
9CBE    // 16 sw   r6, -2(r2)
820F    // 17 lw   r1, 15(r0)
A041    // 18 beqz r1, +1 not taken
1048    // 19 add  r0, r1, r1
1408    // 1a add  r2, r0, r1
F000    // 1b halt

// File: flist.f
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/forward_unit.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/pipeline_cpu.sv
verif/tb_pipeline_cpu.sv

// File: Makefile
TOP := tb_pipeline_cpu
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module pipeline_cpu
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f flist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verif/tb_pipeline_cpu.sv
`timescale 1ns/1ps

module tb_pipeline_cpu;
    import cpu_pkg::*;

    localparam int MAX_STEPS = 1000;

    typedef struct packed {
        logic [31:0] slot;
        reg_idx_t    rd;
        word_t       data;
    } reg_event_t;

    typedef struct packed {
        logic [31:0] slot;
        addr_t       addr;
        word_t       data;
    } store_event_t;

    logic         clk   = 1'b0;
    logic         reset = 1'b1;
    logic         retire_valid;
    reg_idx_t     retire_reg;
    word_t        retire_data;
    logic         store_valid;
    addr_t        store_addr;
    word_t        store_data;
    logic         halted;

    word_t        rom_image [IMEM_DEPTH];
    reg_event_t   exp_regs [$];
    store_event_t exp_stores [$];
    reg_event_t   reg_head;
    store_event_t store_head;
    logic         reg_head_valid   = 1'b0;
    logic         store_head_valid = 1'b0;
    logic [31:0]  cycle            = '0;
    logic [31:0]  base             = '0;
    logic         base_set         = 1'b0;
    logic         model_ok         = 1'b0;
    int           model_steps      = 0;
    int           retires          = 0;
    int           stores           = 0;
    int           mismatches       = 0;
    int           other_errors     = 0;

    pipeline_cpu u_pipeline_cpu (
        .clk          (clk),
        .reset        (reset),
        .retire_valid (retire_valid),
        .retire_reg   (retire_reg),
        .retire_data  (retire_data),
        .store_valid  (store_valid),
        .store_addr   (store_addr),
        .store_data   (store_data),
        .halted       (halted)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // In-order reference model
    ////////////////////////////////////////////////////////////

    // Slot is the issue cycle of an instruction relative to the first one
    task automatic run_model();
        word_t       regs [NUM_REGS];
        word_t       dmem [DMEM_DEPTH];
        addr_t       pc;
        addr_t       ea;
        addr_t       target;
        word_t       instr;
        word_t       a;
        word_t       b;
        word_t       simm6;
        word_t       sum;
        word_t       wr_val;
        opcode_t     op;
        reg_idx_t    rd;
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    src_a;
        reg_idx_t    src_b;
        reg_idx_t    load_rd;
        logic        taken;
        logic        done;
        logic [31:0] slot;
        int          steps;

        for (int i = 0; i < IMEM_DEPTH; i++)
            rom_image[i] = '0;
        $readmemh(PROGRAM_FILE, rom_image);
        for (int i = 0; i < NUM_REGS; i++)
            regs[i] = '0;
        for (int i = 0; i < DMEM_DEPTH; i++)
            dmem[i] = '0;
        pc      = '0;
        slot    = '0;
        load_rd = '0;
        done    = 1'b0;
        steps   = 0;
        while (!done && steps < MAX_STEPS)
        begin
            instr  = rom_image[pc];
            op     = opcode_t'(instr[15:12]);
            rd     = instr[11:9];
            rs     = instr[8:6];
            rt     = instr[5:3];
            simm6  = {{10{instr[5]}}, instr[5:0]};
            a      = regs[rs];
            b      = regs[rt];
            sum    = a + simm6;
            ea     = sum[7:0];
            wr_val = '0;
            taken  = 1'b0;
            src_a  = '0;
            src_b  = '0;
            case (op)
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT:
                begin
                    src_a = rs;
                    src_b = rt;
                end
                OP_ADDI, OP_LW, OP_BEQZ: src_a = rs;
                OP_SW:
                begin
                    src_a = rs;
                    src_b = rd;
                end
                default: src_a = '0;
            endcase
            // A load feeding the very next instruction costs one bubble
            if (load_rd != '0 && (src_a == load_rd || src_b == load_rd))
                slot = slot + 32'd1;
            load_rd = '0;
            case (op)
                OP_ADD:  wr_val = a + b;
                OP_SUB:  wr_val = a - b;
                OP_AND:  wr_val = a & b;
                OP_OR:   wr_val = a | b;
                OP_SLT:  wr_val = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
                OP_ADDI: wr_val = sum;
                OP_LI:   wr_val = {8'h00, instr[7:0]};
                OP_LW:
                begin
                    wr_val  = dmem[ea];
                    load_rd = rd;
                end
                OP_SW:
                begin
                    dmem[ea] = regs[rd];
                    exp_stores.push_back(store_event_t'({slot, ea, regs[rd]}));
                end
                OP_BEQZ: taken = (a == '0);
                OP_B:    taken = 1'b1;
                OP_HALT: done = 1'b1;
                default: wr_val = '0;
            endcase
            if (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT, OP_ADDI, OP_LI, OP_LW}
                && rd != '0)
            begin
                regs[rd] = wr_val;
                exp_regs.push_back(reg_event_t'({slot, rd, wr_val}));
            end
            steps++;
            target = pc + 8'd1 + ((op == OP_B) ? instr[7:0] : simm6[7:0]);
            // Taken branch kills two younger slots
            if (taken)
            begin
                pc   = target;
                slot = slot + 32'd3;
            end
            else
            begin
                pc   = pc + 8'd1;
                slot = slot + 32'd1;
            end
        end
        if (!done)
            $display("Reference model ran %0d steps without reaching HALT", steps);
        model_ok    = done;
        model_steps = steps;
    endtask

    task automatic print_counts(input int extra);
        $display("Summary: %0d retires, %0d stores, %0d mismatches, %0d other errors",
                 retires, stores, mismatches, other_errors + extra);
    endtask

    ////////////////////////////////////////////////////////////
    // Expected event heads
    ////////////////////////////////////////////////////////////

    // First observed event fixes the pipeline latency offset
    always @(posedge clk)
    begin
        cycle <= cycle + 32'd1;
        if (!reset && !base_set)
        begin
            if (retire_valid && reg_head_valid)
            begin
                base     <= cycle - reg_head.slot;
                base_set <= 1'b1;
            end
            else if (store_valid && store_head_valid)
            begin
                base     <= cycle - store_head.slot;
                base_set <= 1'b1;
            end
        end
        if (!reset && retire_valid)
            retires <= retires + 1;
        if (!reset && store_valid)
            stores <= stores + 1;
        if ((!reset && retire_valid) || !reg_head_valid)
        begin
            if (exp_regs.size() > 0)
            begin
                reg_head       <= exp_regs.pop_front();
                reg_head_valid <= 1'b1;
            end
            else
                reg_head_valid <= 1'b0;
        end
        if ((!reset && store_valid) || !store_head_valid)
        begin
            if (exp_stores.size() > 0)
            begin
                store_head       <= exp_stores.pop_front();
                store_head_valid <= 1'b1;
            end
            else
                store_head_valid <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks, sampled mid-cycle
    ////////////////////////////////////////////////////////////

    assert property (@(negedge clk) disable iff (reset) retire_valid |-> reg_head_valid)
    else
    begin
        other_errors++;
        $display("%0t: register write r%0d = %h retired with none expected",
                 $time, retire_reg, retire_data);
    end

    assert property (@(negedge clk) disable iff (reset)
        retire_valid && reg_head_valid |-> retire_reg == reg_head.rd
                                           && retire_data == reg_head.data)
    else
    begin
        mismatches++;
        $display("MISMATCH %0t: retired r%0d = %h, expected r%0d = %h",
                 $time, retire_reg, retire_data, reg_head.rd, reg_head.data);
    end

    assert property (@(negedge clk) disable iff (reset)
        retire_valid && reg_head_valid && base_set |-> cycle - reg_head.slot == base)
    else
    begin
        mismatches++;
        $display("MISMATCH %0t: r%0d retired at offset %0d, expected %0d",
                 $time, retire_reg, cycle - reg_head.slot, base);
    end

    assert property (@(negedge clk) disable iff (reset) store_valid |-> store_head_valid)
    else
    begin
        other_errors++;
        $display("%0t: store of %h to %h with none expected", $time, store_data, store_addr);
    end

    assert property (@(negedge clk) disable iff (reset)
        store_valid && store_head_valid |-> store_addr == store_head.addr
                                           && store_data == store_head.data)
    else
    begin
        mismatches++;
        $display("MISMATCH %0t: store %h to %h, expected %h to %h",
                 $time, store_data, store_addr, store_head.data, store_head.addr);
    end

    assert property (@(negedge clk) disable iff (reset)
        store_valid && store_head_valid && base_set |-> cycle - store_head.slot == base)
    else
    begin
        mismatches++;
        $display("MISMATCH %0t: store to %h at offset %0d, expected %0d",
                 $time, store_addr, cycle - store_head.slot, base);
    end

    assert property (@(negedge clk) disable iff (reset) halted |-> !retire_valid && !store_valid)
    else
    begin
        other_errors++;
        $display("%0t: retire or store seen after halt", $time);
    end

    assert property (@(negedge clk) disable iff (reset)
        halted |-> !reg_head_valid && !store_head_valid)
    else
    begin
        other_errors++;
        $display("%0t: halted with expected writes or stores still outstanding", $time);
    end

    ////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////

    initial
    begin
        run_model();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        while (halted !== 1'b1)
            @(posedge clk);
        // Let any stray retire after halt show up
        repeat (6) @(posedge clk);
        print_counts(model_ok ? 0 : 1);
        if (model_ok && mismatches == 0 && other_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial
    begin
        wait (model_steps > 0);
        repeat (model_steps * 4 + 100 + 4) @(posedge clk);
        $display("Timeout: HALT not reached within %0d cycles after reset",
                 model_steps * 4 + 100);
        print_counts(1);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: hw/pipeline_cpu.sv
`timescale 1ns/1ps

module pipeline_cpu (
    input  logic              clk,
    input  logic              reset,
    output logic              retire_valid,
    output cpu_pkg::reg_idx_t retire_reg,
    output cpu_pkg::word_t    retire_data,
    output logic              store_valid,
    output cpu_pkg::addr_t    store_addr,
    output cpu_pkg::word_t    store_data,
    output logic              halted
);
    import cpu_pkg::*;

    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    logic     halt_seen;
    reg_idx_t dec_rs;
    reg_idx_t dec_rt;
    logic     stall;
    logic     clear_if;
    logic     clear_id;
    fwd_sel_t sel_a;
    fwd_sel_t sel_b;
    word_t    mem_result;
    logic     redirect;
    addr_t    redirect_pc;
    logic     halted_q;

    ////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////

    fetch_stage u_fetch (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .halt_seen   (halt_seen),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .clear       (clear_if),
        .if_id       (if_id)
    );

    decode_stage u_decode (
        .clk       (clk),
        .reset     (reset),
        .if_id     (if_id),
        .wb        (mem_wb),
        .stall     (stall),
        .clear     (clear_id),
        .id_ex     (id_ex),
        .halt_seen (halt_seen),
        .rs        (dec_rs),
        .rt        (dec_rt)
    );

    hazard_unit u_hazard (
        .id_ex    (id_ex),
        .rs       (dec_rs),
        .rt       (dec_rt),
        .taken    (redirect),
        .stall    (stall),
        .clear_if (clear_if),
        .clear_id (clear_id)
    );

    forward_unit u_forward (
        .rs     (id_ex.rs),
        .rt     (id_ex.rt),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb),
        .sel_a  (sel_a),
        .sel_b  (sel_b)
    );

    execute_stage u_execute (
        .clk         (clk),
        .reset       (reset),
        .id_ex       (id_ex),
        .sel_a       (sel_a),
        .sel_b       (sel_b),
        .mem_result  (mem_result),
        .wb          (mem_wb),
        .ex_mem      (ex_mem),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    memory_stage u_memory (
        .clk         (clk),
        .reset       (reset),
        .ex_mem      (ex_mem),
        .mem_result  (mem_result),
        .mem_wb      (mem_wb),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data)
    );

    ////////////////////////////////////////////////////////////
    // Observation ports
    ////////////////////////////////////////////////////////////

    // Writes to r0 are not architectural retirements
    assign retire_valid = mem_wb.valid && mem_wb.reg_write && mem_wb.rd != '0;
    assign retire_reg   = mem_wb.rd;
    assign retire_data  = mem_wb.result;

    // Sticky once HALT leaves the pipe
    always_ff @(posedge clk)
    begin
        if (reset)
            halted_q <= 1'b0;
        else if (mem_wb.valid && mem_wb.halt)
            halted_q <= 1'b1;
    end

    assign halted = halted_q || (mem_wb.valid && mem_wb.halt);

endmodule

// File: hw/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic             clk,
    input  logic             reset,
    input  cpu_pkg::ex_mem_t ex_mem,
    output cpu_pkg::word_t   mem_result,
    output cpu_pkg::mem_wb_t mem_wb,
    output logic             store_valid,
    output cpu_pkg::addr_t   store_addr,
    output cpu_pkg::word_t   store_data
);
    import cpu_pkg::*;

    word_t dmem [DMEM_DEPTH];
    addr_t addr;
    logic  do_store;

    initial
    begin
        for (int i = 0; i < DMEM_DEPTH; i++)
            dmem[i] = '0;
    end

    assign addr     = ex_mem.alu_result[7:0];
    assign do_store = ex_mem.valid && ex_mem.mem_write;

    // Asynchronous read, also the forwarding source for execute
    assign mem_result = ex_mem.mem_read ? dmem[addr] : ex_mem.alu_result;

    always_ff @(posedge clk)
    begin
        if (do_store)
            dmem[addr] <= ex_mem.store_data;
        store_addr <= addr;
        store_data <= ex_mem.store_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            store_valid <= 1'b0;
            mem_wb      <= '0;
        end
        else
        begin
            store_valid      <= do_store;
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.result    <= mem_result;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.halt      <= ex_mem.halt;
        end
    end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::id_ex_t   id_ex,
    input  cpu_pkg::fwd_sel_t sel_a,
    input  cpu_pkg::fwd_sel_t sel_b,
    input  cpu_pkg::word_t    mem_result,
    input  cpu_pkg::mem_wb_t  wb,
    output cpu_pkg::ex_mem_t  ex_mem,
    output logic              redirect,
    output cpu_pkg::addr_t    redirect_pc
);
    import cpu_pkg::*;

    word_t   op_a;
    word_t   op_b;
    word_t   alu_b;
    word_t   alu_result;
    ex_mem_t next;

    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val);
        case (sel)
            FWD_MEM: return mem_result;
            FWD_WB:  return wb.result;
            default: return reg_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(sel_a, id_ex.operand_a);
    assign op_b  = fwd_mux(sel_b, id_ex.operand_b);
    assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

    always_comb
    begin
        case (id_ex.alu_op)
            ALU_SUB:    alu_result = op_a - alu_b;
            ALU_AND:    alu_result = op_a & alu_b;
            ALU_OR:     alu_result = op_a | alu_b;
            ALU_SLT:    alu_result = ($signed(op_a) < $signed(alu_b)) ? 16'd1 : 16'd0;
            ALU_PASS_B: alu_result = alu_b;
            default:    alu_result = op_a + alu_b;
        endcase
    end

    // Target is relative to the branch address plus one
    assign redirect    = id_ex.valid
                         && (id_ex.branch_always || (id_ex.branch_zero && op_a == '0));
    assign redirect_pc = id_ex.pc + addr_t'(1) + id_ex.imm[7:0];

    always_comb
    begin
        next.valid      = id_ex.valid;
        next.alu_result = alu_result;
        next.store_data = op_b;
        next.rd         = id_ex.rd;
        next.mem_read   = id_ex.mem_read;
        next.mem_write  = id_ex.mem_write;
        next.reg_write  = id_ex.reg_write;
        next.halt       = id_ex.halt;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            ex_mem <= '0;
        else
            ex_mem <= next;
    end

    // Only a valid branch redirects, and its shadow in execute is a bubble
    assert property (@(posedge clk) disable iff (reset)
        redirect |-> id_ex.valid && (id_ex.branch_zero || id_ex.branch_always)
                     ##1 !id_ex.valid)
        else $error("redirect without a valid branch or shadow not flushed");

endmodule

// File: hw/forward_unit.sv
`timescale 1ns/1ps

module forward_unit (
    input  cpu_pkg::reg_idx_t rs,
    input  cpu_pkg::reg_idx_t rt,
    input  cpu_pkg::ex_mem_t  ex_mem,
    input  cpu_pkg::mem_wb_t  mem_wb,
    output cpu_pkg::fwd_sel_t sel_a,
    output cpu_pkg::fwd_sel_t sel_b
);
    import cpu_pkg::*;

    // Newest producer first
    function automatic fwd_sel_t pick(input reg_idx_t src);
        if (src == '0)
            return FWD_REG;
        if (ex_mem.valid && ex_mem.reg_write && ex_mem.rd == src)
            return FWD_MEM;
        if (mem_wb.valid && mem_wb.reg_write && mem_wb.rd == src)
            return FWD_WB;
        return FWD_REG;
    endfunction

    assign sel_a = pick(rs);
    assign sel_b = pick(rt);

endmodule

// File: hw/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  cpu_pkg::id_ex_t   id_ex,
    input  cpu_pkg::reg_idx_t rs,
    input  cpu_pkg::reg_idx_t rt,
    input  logic              taken,
    output logic              stall,
    output logic              clear_if,
    output logic              clear_id
);
    import cpu_pkg::*;

    logic load_in_ex;
    logic load_use;

    // Load data only exists after memory, so a dependent in decode waits
    assign load_in_ex = id_ex.valid && id_ex.mem_read && id_ex.rd != reg_idx_t'(0);
    assign load_use   = load_in_ex && (id_ex.rd == rs || id_ex.rd == rt);

    assign stall = load_use;

    // Taken branch kills the two younger instructions
    assign clear_if = taken;
    assign clear_id = taken;

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::if_id_t   if_id,
    input  cpu_pkg::mem_wb_t  wb,
    input  logic              stall,
    input  logic              clear,
    output cpu_pkg::id_ex_t   id_ex,
    output logic              halt_seen,
    output cpu_pkg::reg_idx_t rs,
    output cpu_pkg::reg_idx_t rt
);
    import cpu_pkg::*;

    opcode_t op;
    word_t   simm6;
    word_t   simm8;
    id_ex_t  dec;
    word_t   regs [NUM_REGS];

    assign op    = opcode_t'(if_id.instr[15:12]);
    assign simm6 = {{10{if_id.instr[5]}}, if_id.instr[5:0]};
    assign simm8 = {{8{if_id.instr[7]}}, if_id.instr[7:0]};

    // r0 reads zero, same-cycle writeback is bypassed
    function automatic word_t read_reg(input reg_idx_t idx);
        if (idx == '0)
            return '0;
        if (wb.valid && wb.reg_write && wb.rd == idx)
            return wb.result;
        return regs[idx];
    endfunction

    ////////////////////////////////////////////////////////////
    // Decoder
    ////////////////////////////////////////////////////////////

    // Unused source fields stay r0 so they never match a hazard
    always_comb
    begin
        dec = '0;
        dec.alu_op = ALU_ADD;
        if (if_id.valid)
        begin
            dec.valid = 1'b1;
            dec.pc    = if_id.pc;
            case (op)
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT:
                begin
                    dec.rs        = if_id.instr[8:6];
                    dec.rt        = if_id.instr[5:3];
                    dec.rd        = if_id.instr[11:9];
                    dec.reg_write = 1'b1;
                    case (op)
                        OP_SUB:  dec.alu_op = ALU_SUB;
                        OP_AND:  dec.alu_op = ALU_AND;
                        OP_OR:   dec.alu_op = ALU_OR;
                        OP_SLT:  dec.alu_op = ALU_SLT;
                        default: dec.alu_op = ALU_ADD;
                    endcase
                end
                OP_ADDI, OP_LW:
                begin
                    dec.rs        = if_id.instr[8:6];
                    dec.rd        = if_id.instr[11:9];
                    dec.imm       = simm6;
                    dec.use_imm   = 1'b1;
                    dec.mem_read  = (op == OP_LW);
                    dec.reg_write = 1'b1;
                end
                OP_LI:
                begin
                    dec.rd        = if_id.instr[11:9];
                    dec.imm       = {8'h00, if_id.instr[7:0]};
                    dec.use_imm   = 1'b1;
                    dec.alu_op    = ALU_PASS_B;
                    dec.reg_write = 1'b1;
                end
                // Store data comes from the rd field
                OP_SW:
                begin
                    dec.rs        = if_id.instr[8:6];
                    dec.rt        = if_id.instr[11:9];
                    dec.imm       = simm6;
                    dec.use_imm   = 1'b1;
                    dec.mem_write = 1'b1;
                end
                OP_BEQZ:
                begin
                    dec.rs          = if_id.instr[8:6];
                    dec.imm         = simm6;
                    dec.branch_zero = 1'b1;
                end
                OP_B:
                begin
                    dec.imm           = simm8;
                    dec.branch_always = 1'b1;
                end
                OP_HALT: dec.halt = 1'b1;
                default: dec.halt = 1'b0;
            endcase
        end
        dec.operand_a = read_reg(dec.rs);
        dec.operand_b = read_reg(dec.rt);
    end

    assign halt_seen = dec.halt;
    assign rs        = dec.rs;
    assign rt        = dec.rt;

    ////////////////////////////////////////////////////////////
    // Register file and decode/execute register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        else if (wb.valid && wb.reg_write && wb.rd != '0)
            regs[wb.rd] <= wb.result;
    end

    // Bubble on stall or flush
    always_ff @(posedge clk)
    begin
        if (reset || stall || clear)
            id_ex <= '0;
        else
            id_ex <= dec;
    end

    assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
        else $error("r0 holds a nonzero value");

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            halt_seen,
    input  logic            redirect,
    input  cpu_pkg::addr_t  redirect_pc,
    input  logic            clear,
    output cpu_pkg::if_id_t if_id
);
    import cpu_pkg::*;

    addr_t pc;
    logic  stopped;
    word_t imem [IMEM_DEPTH];

    // Words past the program image decode as NOP
    initial
    begin
        for (int i = 0; i < IMEM_DEPTH; i++)
            imem[i] = '0;
        $readmemh(PROGRAM_FILE, imem);
    end

    // Redirect wins over stall and over a wrong-path HALT in decode
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc      <= '0;
            stopped <= 1'b0;
        end
        else
        begin
            if (halt_seen && !redirect)
                stopped <= 1'b1;
            if (redirect)
                pc <= redirect_pc;
            else if (!stall && !halt_seen && !stopped)
                pc <= pc + addr_t'(1);
        end
    end

    // Fetch/decode register, held on stall
    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            if_id.pc    <= pc;
            if_id.instr <= imem[pc];
        end
        if (reset)
            if_id.valid <= 1'b0;
        else if (clear || halt_seen || stopped)
            if_id.valid <= 1'b0;
        else if (!stall)
            if_id.valid <= 1'b1;
    end

    // A load in execute is never a branch
    assert property (@(posedge clk) disable iff (reset) !(stall && redirect))
        else $error("stall and redirect raised together");

endmodule

// File: hw/cpu_pkg.sv
package cpu_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////////////////////////

    typedef logic [15:0] word_t;
    typedef logic [7:0]  addr_t;
    typedef logic [2:0]  reg_idx_t;

    localparam int    IMEM_DEPTH   = 256;
    localparam int    DMEM_DEPTH   = 256;
    localparam int    NUM_REGS     = 8;
    localparam string PROGRAM_FILE = "verif/program.hex";

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    // Opcode in instr[15:12]
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_SLT  = 4'h5,
        OP_ADDI = 4'h6,
        OP_LI   = 4'h7,
        OP_LW   = 4'h8,
        OP_SW   = 4'h9,
        OP_BEQZ = 4'ha,
        OP_B    = 4'hb,
        OP_HALT = 4'hf
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    ////////////////////////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  valid;
        addr_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        alu_op_t  alu_op;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        word_t    operand_a;
        word_t    operand_b;
        word_t    imm;
        logic     use_imm;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        logic     branch_zero;
        logic     branch_always;
        logic     halt;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t rd;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        logic     halt;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    result;
        logic     reg_write;
        logic     halt;
    } mem_wb_t;

endpackage
